// ==== src/synth_consts.svh ====
`ifndef SYNTH_CONSTS_SVH
`define SYNTH_CONSTS_SVH

// Command bytes
`define CMD_NOISE_ON   8'h4E   // 'N'
`define CMD_NOISE_OFF  8'h46   // 'F'
`define CMD_TRI        8'h54   // 'T'
`define CMD_SAW        8'h53   // 'S'
`define CMD_SQUARE     8'h51   // 'Q'
`define CMD_SINE       8'h57   // 'W'

// Note characters
`define CHR_DIGIT_LO   8'h30   // '0' is note 0
`define CHR_DIGIT_HI   8'h39
`define CHR_LETTER_LO  8'h41   // 'A' is note 10
`define CHR_LETTER_HI  8'h5A
`define NOTE_LETTER_BASE 8'd10

// Dividers of the top octave, C4 to B4
`define NOTE_BASE_0    18'd47878
`define NOTE_BASE_1    18'd45090
`define NOTE_BASE_2    18'd42566
`define NOTE_BASE_3    18'd40178
`define NOTE_BASE_4    18'd37878
`define NOTE_BASE_5    18'd35793
`define NOTE_BASE_6    18'd33783
`define NOTE_BASE_7    18'd31888
`define NOTE_BASE_8    18'd30120
`define NOTE_BASE_9    18'd28409
`define NOTE_BASE_10   18'd26881
`define NOTE_BASE_11   18'd25434

`define LFSR_SEED      16'hACE1
`define LFSR_TAPS      16'hB400   // Bits 16, 14, 13, 11
`define ENV_HOLD_CYCLES 256
`define SINE_STEPS     16
`define I2S_WORD_BITS  16

`endif

// ==== src/synth_pkg.sv ====
package synth_pkg;

    typedef logic [7:0] sample_t;  // Unsigned audio sample
    typedef logic [7:0] knob_t;    // Envelope setting from a knob
    typedef logic [5:0] note_t;    // Note index 0 to 35
    typedef logic [17:0] div_t;    // Clock divider count

    typedef enum logic [1:0] {
        wave_tri    = 2'd0,
        wave_saw    = 2'd1,
        wave_square = 2'd2,
        wave_sine   = 2'd3
    } wave_t;

    // Envelope phases, one after the other
    typedef enum logic [2:0] {
        env_idle    = 3'd0,
        env_attack  = 3'd1,
        env_decay   = 3'd2,
        env_sustain = 3'd3,
        env_release = 3'd4
    } env_state_t;

endpackage

// ==== src/adsr_ctrl_if.sv ====
`timescale 1ns/10ps

interface adsr_ctrl_if import synth_pkg::*; ();

    knob_t attack;        // Attack ceiling
    knob_t decay;         // Decay step per clock
    knob_t sustain;       // Sustain level
    knob_t release_rate;  // Release step per clock

    modport knobs (output attack, output decay, output sustain, output release_rate);

    modport env (input attack, input decay, input sustain, input release_rate);

endinterface

// ==== src/uart_cmd_rx.sv ====
`timescale 1ns/10ps

`include "synth_consts.svh"

module uart_cmd_rx import synth_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx,
    output note_t note,
    output wave_t wave,
    output logic  noise_en
);

    typedef enum logic [1:0] {rx_idle, rx_data, rx_decode} rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_s;      // Synchronized line
    logic       rx_last;
    logic [2:0] bit_cnt;
    logic [7:0] rx_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
            rx_last <= rx_s;
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == rx_data)
            rx_byte <= {rx_s, rx_byte[7:1]};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= rx_idle;
            bit_cnt  <= 3'd0;
            note     <= '0;
            wave     <= wave_tri;
            noise_en <= 1'b0;
        end else begin
            case (state)
                rx_idle: begin
                    bit_cnt <= 3'd0;
                    if (rx_last && !rx_s)  // Start bit
                        state <= rx_data;
                end
                rx_data: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7)
                        state <= rx_decode;
                end
                default: begin
                    case (rx_byte)
                        `CMD_NOISE_ON:  noise_en <= 1'b1;
                        `CMD_NOISE_OFF: noise_en <= 1'b0;
                        `CMD_TRI:       wave     <= wave_tri;
                        `CMD_SAW:       wave     <= wave_saw;
                        `CMD_SQUARE:    wave     <= wave_square;
                        `CMD_SINE:      wave     <= wave_sine;
                        default: begin
                            if (rx_byte >= `CHR_DIGIT_LO && rx_byte <= `CHR_DIGIT_HI)
                                note <= note_t'(rx_byte - `CHR_DIGIT_LO);
                            else if (rx_byte >= `CHR_LETTER_LO && rx_byte <= `CHR_LETTER_HI)
                                note <= note_t'(rx_byte - `CHR_LETTER_LO + `NOTE_LETTER_BASE);
                        end
                    endcase
                    state <= rx_idle;
                end
            endcase
        end
    end

endmodule

// ==== src/quad_decoder.sv ====
`timescale 1ns/10ps

module quad_decoder import synth_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ena,
    input  logic  a,
    input  logic  b,
    output knob_t value
);

    logic a_prev;
    logic b_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_prev <= 1'b0;
            b_prev <= 1'b0;
            value  <= '0;
        end else if (ena) begin
            a_prev <= a;
            b_prev <= b;
            case ({a, a_prev, b, b_prev})
                4'b1000, 4'b0111: value <= value + 8'd1;  // Forward
                4'b0010, 4'b1101: value <= value - 8'd1;  // Reverse
                default:          value <= value;
            endcase
        end
    end

endmodule

// ==== src/note_divider.sv ====
`timescale 1ns/10ps

`include "synth_consts.svh"

module note_divider import synth_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ena,
    input  note_t note,
    output logic  step
);

    note_t      pos;      // Position within the octave
    logic [1:0] octave;
    div_t       base;
    div_t       divider;
    div_t       count;

    always_comb begin
        if (note >= 6'd24) begin
            octave = 2'd2;
            pos    = note - 6'd24;
        end else if (note >= 6'd12) begin
            octave = 2'd1;
            pos    = note - 6'd12;
        end else begin
            octave = 2'd0;
            pos    = note;
        end
    end

    always_comb begin
        case (pos)
            6'd0:    base = `NOTE_BASE_0;
            6'd1:    base = `NOTE_BASE_1;
            6'd2:    base = `NOTE_BASE_2;
            6'd3:    base = `NOTE_BASE_3;
            6'd4:    base = `NOTE_BASE_4;
            6'd5:    base = `NOTE_BASE_5;
            6'd6:    base = `NOTE_BASE_6;
            6'd7:    base = `NOTE_BASE_7;
            6'd8:    base = `NOTE_BASE_8;
            6'd9:    base = `NOTE_BASE_9;
            6'd10:   base = `NOTE_BASE_10;
            default: base = `NOTE_BASE_11;
        endcase
    end

    // Lower octaves double the period
    assign divider = base << (2'd2 - octave);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            step  <= 1'b0;
        end else if (ena) begin
            if (count >= divider) begin  // Also catches a shorter new note
                count <= '0;
                step  <= 1'b1;
            end else begin
                count <= count + 1'b1;
                step  <= 1'b0;
            end
        end
    end

endmodule

// ==== src/osc_bank.sv ====
`timescale 1ns/10ps

`include "synth_consts.svh"

module osc_bank import synth_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ena,
    input  logic    step,
    input  logic    noise_en,
    input  wave_t   wave,
    output sample_t sample
);

    localparam int SINE_W = $clog2(`SINE_STEPS);

    sample_t           tri_cnt;
    logic              tri_up;      // Triangle direction
    sample_t           saw_cnt;
    logic              sq_high;
    logic [SINE_W-1:0] sine_idx;
    logic [15:0]       lfsr;
    sample_t           wave_val;

    function automatic sample_t sine_lut(input logic [SINE_W-1:0] idx);
        case (idx)
            4'd0:    return 8'd128;
            4'd1:    return 8'd176;
            4'd2:    return 8'd218;
            4'd3:    return 8'd246;
            4'd4:    return 8'd255;
            4'd5:    return 8'd246;
            4'd6:    return 8'd218;
            4'd7:    return 8'd176;
            4'd8:    return 8'd128;
            4'd9:    return 8'd80;
            4'd10:   return 8'd38;
            4'd11:   return 8'd10;
            4'd12:   return 8'd0;
            4'd13:   return 8'd10;
            4'd14:   return 8'd38;
            default: return 8'd80;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tri_cnt  <= '0;
            tri_up   <= 1'b1;
            saw_cnt  <= '0;
            sq_high  <= 1'b0;
            sine_idx <= '0;
        end else if (ena && step) begin
            if (tri_up) begin
                if (tri_cnt < 8'd255) tri_cnt <= tri_cnt + 8'd1;
                else                  tri_up  <= 1'b0;  // Turn at the top
            end else begin
                if (tri_cnt > 8'd0) tri_cnt <= tri_cnt - 8'd1;
                else                tri_up  <= 1'b1;
            end
            saw_cnt  <= saw_cnt + 8'd1;
            sq_high  <= ~sq_high;
            sine_idx <= sine_idx + 1'b1;
        end
    end

    // Fibonacci LFSR, only clocked in noise mode
    always_ff @(posedge clk) begin
        if (!rst_n)
            lfsr <= `LFSR_SEED;
        else if (ena && noise_en)
            lfsr <= {lfsr[14:0], ^(lfsr & `LFSR_TAPS)};
    end

    always_comb begin
        case (wave)
            wave_tri:    wave_val = tri_cnt;
            wave_saw:    wave_val = saw_cnt;
            wave_square: wave_val = sq_high ? 8'd255 : 8'd0;
            default:     wave_val = sine_lut(sine_idx);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            sample <= '0;
        else if (ena)
            sample <= noise_en ? lfsr[15:8] : wave_val;
    end

endmodule

// ==== src/adsr_vca.sv ====
`timescale 1ns/10ps

`include "synth_consts.svh"

module adsr_vca import synth_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ena,
    adsr_ctrl_if.env ctrl,
    input  sample_t sample_in,
    output sample_t sample_out
);

    localparam int HOLD_W = $clog2(`ENV_HOLD_CYCLES);
    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`ENV_HOLD_CYCLES - 1);

    env_state_t        state;
    knob_t             amp;       // Current envelope level
    logic [HOLD_W-1:0] hold_cnt;
    logic [15:0]       product;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= env_idle;
            amp      <= '0;
            hold_cnt <= '0;
        end else if (ena) begin
            case (state)
                env_idle: begin
                    hold_cnt <= hold_cnt + 1'b1;
                    if (hold_cnt == HOLD_LAST) state <= env_attack;
                end
                env_attack: begin
                    if (amp < ctrl.attack) amp   <= amp + 8'd1;
                    else                   state <= env_decay;
                end
                env_decay: begin
                    if (amp > ctrl.sustain) begin
                        if (amp - ctrl.sustain > ctrl.decay) amp <= amp - ctrl.decay;
                        else                                 amp <= ctrl.sustain;
                    end else begin
                        state <= env_sustain;
                    end
                end
                env_sustain: begin
                    amp      <= ctrl.sustain;
                    hold_cnt <= hold_cnt + 1'b1;
                    if (hold_cnt == HOLD_LAST) state <= env_release;
                end
                env_release: begin
                    // Stalls here while the release setting is zero
                    if (amp > ctrl.release_rate) amp <= amp - ctrl.release_rate;
                    else if (amp != 8'd0)        amp <= '0;
                    else                         state <= env_idle;
                end
                default: state <= env_idle;
            endcase
        end
    end

    assign product = sample_in * amp;

    always_ff @(posedge clk) begin
        if (!rst_n)
            sample_out <= '0;
        else if (ena)
            sample_out <= product[15:8];  // Upper byte of the scaled sample
    end

endmodule

// ==== src/i2s_tx.sv ====
`timescale 1ns/10ps

`include "synth_consts.svh"

module i2s_tx import synth_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ena,
    input  sample_t sample,
    output logic    sck,
    output logic    ws,
    output logic    sd
);

    localparam int BIT_W = $clog2(`I2S_WORD_BITS);

    logic [BIT_W-1:0]          bit_cnt;
    logic [`I2S_WORD_BITS-1:0] word;    // Doubled sample
    logic [`I2S_WORD_BITS-1:0] shreg;

    assign word = {sample, sample};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= '0;
            shreg   <= '0;
        end else if (ena) begin
            sck <= ~sck;
            if (sck) begin  // sck falls, data moves
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == '1) begin
                    ws    <= ~ws;
                    sd    <= word[`I2S_WORD_BITS-1];
                    shreg <= {word[`I2S_WORD_BITS-2:0], 1'b0};
                end else begin
                    sd    <= shreg[`I2S_WORD_BITS-1];
                    shreg <= {shreg[`I2S_WORD_BITS-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// ==== src/synth_top.sv ====
`timescale 1ns/10ps

module synth_top import synth_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ena,
    input  logic [7:0] ui_in,
    input  logic [7:0] uio_in,
    output logic [7:0] uo_out,
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe
);

    note_t   note;
    wave_t   wave;
    logic    noise_en;
    logic    step;
    sample_t osc_sample;
    sample_t vca_sample;
    logic    i2s_sck;
    logic    i2s_ws;
    logic    i2s_sd;

    adsr_ctrl_if ctrl_if ();

    uart_cmd_rx cmd_rx_i (
        .clk(clk), .rst_n(rst_n), .rx(ui_in[0]),
        .note(note), .wave(wave), .noise_en(noise_en)
    );

    // One knob per pair of uio pins
    quad_decoder attack_knob_i (
        .clk(clk), .rst_n(rst_n), .ena(ena),
        .a(uio_in[0]), .b(uio_in[1]), .value(ctrl_if.attack)
    );
    quad_decoder decay_knob_i (
        .clk(clk), .rst_n(rst_n), .ena(ena),
        .a(uio_in[2]), .b(uio_in[3]), .value(ctrl_if.decay)
    );
    quad_decoder sustain_knob_i (
        .clk(clk), .rst_n(rst_n), .ena(ena),
        .a(uio_in[4]), .b(uio_in[5]), .value(ctrl_if.sustain)
    );
    quad_decoder release_knob_i (
        .clk(clk), .rst_n(rst_n), .ena(ena),
        .a(uio_in[6]), .b(uio_in[7]), .value(ctrl_if.release_rate)
    );

    note_divider note_div_i (
        .clk(clk), .rst_n(rst_n), .ena(ena), .note(note), .step(step)
    );

    osc_bank osc_i (
        .clk(clk), .rst_n(rst_n), .ena(ena), .step(step),
        .noise_en(noise_en), .wave(wave), .sample(osc_sample)
    );

    adsr_vca vca_i (
        .clk(clk), .rst_n(rst_n), .ena(ena), .ctrl(ctrl_if.env),
        .sample_in(osc_sample), .sample_out(vca_sample)
    );

    i2s_tx i2s_i (
        .clk(clk), .rst_n(rst_n), .ena(ena), .sample(vca_sample),
        .sck(i2s_sck), .ws(i2s_ws), .sd(i2s_sd)
    );

    assign uo_out  = {5'b00000, i2s_sd, i2s_ws, i2s_sck};
    assign uio_out = 8'h00;
    assign uio_oe  = 8'h00;  // All uio pins are inputs

endmodule

// ==== tests/synth_tb_tasks.svh ====
task automatic report_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
endtask

task automatic check_sample(input sample_t got, input sample_t exp, input string what);
    if (got !== exp)
        report_error($sformatf("MISMATCH at %0t: %s is %0d, expected %0d",
                               $time, what, got, exp));
endtask

task automatic check_ceiling(input sample_t got, input sample_t limit, input string what);
    if ($isunknown(got) || got > limit)
        report_error($sformatf("MISMATCH at %0t: %s is %0d, above the ceiling %0d",
                               $time, what, got, limit));
endtask

task automatic check_bits(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp)
        report_error($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                               $time, what, got, exp));
endtask

task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
        report_error($sformatf("MISMATCH at %0t: %s is %0d, expected %0d",
                               $time, what, got, exp));
endtask

// One frame: start bit, 8 data bits LSB first, then idle
task automatic send_cmd(input logic [7:0] cmd);
    ui_in[0] = 1'b0;
    @(negedge clk);
    for (int i = 0; i < 8; i++) begin
        ui_in[0] = cmd[i];
        @(negedge clk);
    end
    ui_in[0] = 1'b1;
    repeat (20) @(negedge clk);
endtask

// Two Gray code transitions give one count on the knob
task automatic turn_knob(input int index, input int steps);
    logic [1:0] ba;
    for (int t = 0; t < 2 * steps; t++) begin
        knob_pos[index] = (knob_pos[index] + 1) % 4;
        case (knob_pos[index])
            0:       ba = 2'b00;
            1:       ba = 2'b01;  // a rises with b low
            2:       ba = 2'b11;
            default: ba = 2'b10;  // a falls with b high
        endcase
        uio_in[2 * index +: 2] = ba;
        repeat (2) @(negedge clk);
    end
endtask

task automatic wait_words(input int count);
    while (words.size() < count) @(negedge clk);
endtask

// Drops the words that were in flight when a setting changed
task automatic flush_words(input int count);
    words.delete();
    wait_words(count);
    words.delete();
endtask

task automatic check_words(input int count, input sample_t limit, input string what);
    for (int i = 0; i < count; i++) begin
        check_bits(words[i][7:0], words[i][15:8], "second byte of an I2S word");
        check_ceiling(words[i][15:8], limit, what);
    end
endtask

task automatic check_square_capture(input string what);
    logic seen_low;
    logic seen_high;
    int   count;
    seen_low  = 1'b0;
    seen_high = 1'b0;
    flush_words(2);
    repeat (SQUARE_WINDOW) @(negedge clk);
    count = words.size();
    check_words(count, ceiling, what);
    for (int i = 0; i < count; i++) begin
        if (words[i][15:8] == 8'h00) begin
            seen_low = 1'b1;
        end else begin
            check_sample(words[i][15:8], ceiling, what);
            seen_high = 1'b1;
        end
    end
    if (!seen_low || !seen_high)
        report_error($sformatf("%s: the square wave did not show both levels", what));
endtask

task automatic test_reset_silence();
    $display("Test: reset and silence");
    check_bits(uo_out & 8'hF8, 8'h00, "unused uo_out bits");
    check_bits(uio_out, 8'h00, "uio_out");
    check_bits(uio_oe, 8'h00, "uio_oe");
    words.delete();
    wait_words(40);
    check_words(40, 8'd0, "silent sample");
endtask

task automatic test_i2s_framing();
    int         period;
    logic       ws_last;
    logic [7:0] held;
    $display("Test: I2S framing");
    for (int i = 0; i < 9; i++) begin
        period  = 0;
        ws_last = uo_out[1];
        do begin
            @(negedge clk);
            period++;
        end while (uo_out[1] == ws_last);
        if (i > 0)  // First pass only finds a toggle
            check_count(period, WORD_CYCLES, "clocks between ws toggles");
    end
    ena  = 1'b0;
    held = uo_out & 8'h03;
    repeat (50) begin
        @(negedge clk);
        check_bits(uo_out & 8'h03, held, "sck and ws with ena low");
    end
    ena = 1'b1;
endtask

task automatic test_envelope_ceiling();
    $display("Test: envelope ceiling at level %0d", level);
    turn_knob(0, level);
    turn_knob(2, level);
    // A full turn of release lets a level stalled in release fall back to idle,
    // and leaves the setting at zero again
    turn_knob(3, 256);
    repeat (SETTLE_CYCLES) @(negedge clk);
    send_cmd(`CMD_NOISE_ON);  // Noise spans the whole sample range
    flush_words(2);
    wait_words(40);
    check_words(40, ceiling, "enveloped sample");
    send_cmd(`CMD_NOISE_OFF);
endtask

task automatic test_square_wave();
    $display("Test: square wave");
    send_cmd(`CMD_SQUARE);
    send_cmd("Z");  // Note 35
    check_square_capture("square sample");
endtask

task automatic test_noise_mode();
    bit seen [256];
    int distinct;
    $display("Test: noise mode");
    distinct = 0;
    send_cmd(`CMD_NOISE_ON);
    flush_words(2);
    wait_words(200);
    check_words(200, ceiling, "noise sample");
    for (int i = 0; i < 200; i++) begin
        if (!seen[words[i][15:8]]) begin
            seen[words[i][15:8]] = 1'b1;
            distinct++;
        end
    end
    if (distinct < 8)
        report_error($sformatf("Noise mode gave only %0d distinct values in 200 words",
                               distinct));
    send_cmd(`CMD_NOISE_OFF);
    send_cmd(`CMD_SQUARE);
    check_square_capture("square sample after noise");
endtask

task automatic test_ignored_command();
    $display("Test: ignored command");
    send_cmd("x");
    check_square_capture("square sample after an unknown byte");
endtask

// ==== tests/synth_tb.sv ====
`timescale 1ns/10ps

`include "synth_consts.svh"

module synth_tb import synth_pkg::*; ();

    localparam int WORD_CYCLES   = 2 * `I2S_WORD_BITS;  // Clocks between ws toggles
    localparam int CMD_CYCLES    = 29;                  // Serial frame plus the wait after it
    localparam int SQUARE_WINDOW = 80000;
    localparam int SETTLE_CYCLES = 2 * `ENV_HOLD_CYCLES + 320;
    localparam int MIN_LEVEL     = 20;
    localparam int MAX_LEVEL     = 200;

    // Cycle budget of each test
    localparam int BUDGET_RESET    = 10 + 45 * WORD_CYCLES;
    localparam int BUDGET_FRAMING  = 10 * WORD_CYCLES + 50;
    localparam int BUDGET_ENVELOPE = 4 * (2 * MAX_LEVEL + 256) + SETTLE_CYCLES
                                     + 2 * CMD_CYCLES + 42 * WORD_CYCLES;
    localparam int BUDGET_SQUARE   = 2 * CMD_CYCLES + 3 * WORD_CYCLES + SQUARE_WINDOW;
    localparam int BUDGET_NOISE    = CMD_CYCLES + 202 * WORD_CYCLES + BUDGET_SQUARE;
    localparam int BUDGET_IGNORED  = BUDGET_SQUARE;
    localparam int TEST_CYCLES     = BUDGET_RESET + BUDGET_FRAMING + BUDGET_ENVELOPE
                                     + BUDGET_SQUARE + BUDGET_NOISE + BUDGET_IGNORED;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 5;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    int          level;          // Knob turns for attack and sustain
    sample_t     ceiling;        // Largest scaled sample at that level
    int          knob_pos [4];   // Gray code position of each knob
    logic [15:0] words [$];      // Captured I2S words

    logic        sck_prev;
    logic        ws_prev;
    logic        ws_seen;
    logic [15:0] shift_word;
    int          bit_count;

    synth_top dut_i (
        .clk(clk), .rst_n(rst_n), .ena(ena),
        .ui_in(ui_in), .uio_in(uio_in),
        .uo_out(uo_out), .uio_out(uio_out), .uio_oe(uio_oe)
    );

    always #4 clk = ~clk;

    `include "synth_tb_tasks.svh"

    // I2S capture, one word per ws half period
    always @(negedge clk) begin
        if (!rst_n) begin
            sck_prev   = 1'b0;
            ws_prev    = 1'b0;
            ws_seen    = 1'b0;
            shift_word = '0;
            bit_count  = 0;
        end else begin
            if (uo_out[1] != ws_prev) begin
                if (ws_seen) begin  // First toggle only aligns the capture
                    check_count(bit_count, `I2S_WORD_BITS, "bits in an I2S word");
                    words.push_back(shift_word);
                end
                ws_seen   = 1'b1;
                bit_count = 0;
            end
            if (uo_out[0] && !sck_prev) begin  // sck rose, sd is stable
                shift_word = {shift_word[14:0], uo_out[2]};
                bit_count++;
            end
            sck_prev = uo_out[0];
            ws_prev  = uo_out[1];
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_error("Timeout: the tests did not finish within their cycle budget");
    end

    initial begin
        int seed;
        clk    = 1'b0;
        rst_n  = 1'b0;
        ena    = 1'b1;
        ui_in  = 8'h01;  // Serial line idles high
        uio_in = 8'h00;
        for (int i = 0; i < 4; i++) begin
            knob_pos[i] = 0;
        end
        seed    = $urandom(31);
        level   = $urandom_range(MAX_LEVEL, MIN_LEVEL);
        ceiling = sample_t'((255 * level) / 256);
        repeat (10) @(negedge clk);
        check_bits(uo_out, 8'h00, "uo_out during reset");
        rst_n = 1'b1;
        test_reset_silence();
        test_i2s_framing();
        test_envelope_ceiling();
        test_square_wave();
        test_noise_mode();
        test_ignored_command();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+src
+incdir+tests
src/synth_pkg.sv
src/adsr_ctrl_if.sv
src/uart_cmd_rx.sv
src/quad_decoder.sv
src/note_divider.sv
src/osc_bank.sv
src/adsr_vca.sv
src/i2s_tx.sv
src/synth_top.sv
tests/synth_tb.sv
